/* filelist.f */
src/memsys_pkg.sv
src/req_arbiter.sv
src/spsram32.sv
src/run_timer.sv
src/run_ctrl_fsm.sv
src/sig_dump.sv
src/memsys_top.sv
tests/memsys_properties.sv
tests/memsys_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the memsys testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module memsys_tb -f filelist.f -o memsys_sim

if ! ./obj_dir/memsys_sim > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi
cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi
grep -q "test passed" sim.log

/* tests/memsys_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Plays the core over three runs: tohost halt, timeout halt, empty dump
// Random traffic stays inside words the testbench has already written
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module memsys_tb import memsys_pkg::*; ();

    localparam int CLK_HALF        = 10;
    localparam int WATCHDOG_CYCLES = BOOT_HOLD + 2 * RUN_LIMIT + 2 * SIG_MAX_WORDS + 200;
    localparam int TOHOST_IDX      = 63;
    localparam int RUN1_WORDS      = 64;
    localparam word_t TOHOST_ADDR  = 32'(TOHOST_IDX * 4);

    logic        clk;
    logic        rst;
    logic        instr_req;
    word_t       instr_addr;
    logic        instr_ack;
    word_t       instr_data;
    logic        data_req;
    logic        data_wr_en;
    word_t       data_addr;
    word_t       data_wr_data;
    byte_mask_t  data_wr_mask;
    logic        data_ack;
    word_t       data_rd_data;
    word_t       tohost_addr;
    word_t       sig_begin;
    word_t       sig_end;
    logic        run;
    logic        halted;
    halt_cause_e halt_cause;
    logic        dump_valid;
    word_t       dump_addr;
    word_t       dump_data;

    integer seed;
    int     run_cycles;
    // Shadow of the SRAM contents
    word_t  shadow [MEM_WORDS];

    memsys_top i_memsys_top (.*);

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Run-high cycles since the last reset
    always @(posedge clk) begin
        if (rst) begin
            run_cycles <= 0;
        end else if (run) begin
            run_cycles <= run_cycles + 1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        abort_run();
    end

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_cause(input string name, input halt_cause_e exp, input halt_cause_e act);
        if (act !== exp) begin
            $display("ERR %s expected %s actual %s", name, exp.name(), act.name());
            abort_run();
        end
    endtask

    function automatic int rand_below(input int n);
        word_t r;
        r = $random(seed);
        return int'(r[30:0]) % n;
    endfunction

    function automatic word_t rand_word();
        word_t r;
        r = $random(seed);
        return r;
    endfunction

    // Random bits above the index and in the byte offset, same word
    function automatic word_t alias_addr(input int idx);
        word_t r;
        r = $random(seed);
        return {r[31:11], mem_idx_t'(idx), r[1:0]};
    endfunction

    function automatic mem_idx_t word_of(input word_t addr);
        return addr[10:2];
    endfunction

    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                          input byte_mask_t mask);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Reset, then the boot hold with a fetch pending that must stay unacked
    task automatic start_run(input word_t th, input word_t sb, input word_t se);
        rst         <= 1'b1;
        tohost_addr <= th;
        sig_begin   <= sb;
        sig_end     <= se;
        repeat (3) @(posedge clk);
        rst        <= 1'b0;
        instr_req  <= 1'b1;
        instr_addr <= alias_addr(rand_below(MEM_WORDS));
        for (int k = 0; k < BOOT_HOLD; k++) begin
            @(negedge clk);
            check_bit("boot run", 1'b0, run);
            check_bit("boot instr_ack", 1'b0, instr_ack);
            check_bit("boot data_ack", 1'b0, data_ack);
            check_bit("boot halted", 1'b0, halted);
            check_bit("boot dump_valid", 1'b0, dump_valid);
            check_cause("boot halt_cause", HALT_NONE, halt_cause);
        end
        @(posedge clk);
        instr_req <= 1'b0;
        @(negedge clk);
        check_bit("boot run rise", 1'b1, run);
        check_bit("boot instr_ack", 1'b0, instr_ack);
    endtask

    // One request cycle, then an idle cycle in which the acks are checked
    task automatic bus_cycle(input string name, input logic d_req, input logic d_wr,
                             input word_t d_addr, input word_t d_wdata,
                             input byte_mask_t d_mask, input logic i_req, input word_t i_addr);
        mem_idx_t d_idx;
        d_idx = word_of(d_addr);
        @(posedge clk);
        data_req     <= d_req;
        data_wr_en   <= d_wr;
        data_addr    <= d_addr;
        data_wr_data <= d_wdata;
        data_wr_mask <= d_mask;
        instr_req    <= i_req;
        instr_addr   <= i_addr;
        @(posedge clk);
        data_req   <= 1'b0;
        data_wr_en <= 1'b0;
        instr_req  <= 1'b0;
        @(negedge clk);
        check_bit({name, " run"}, 1'b1, run);
        check_bit({name, " data_ack"}, d_req, data_ack);
        check_bit({name, " instr_ack"}, i_req && !d_req, instr_ack);
        if (d_req) begin
            // A write also returns the word as it was before the write
            check_word({name, " data_rd_data"}, shadow[d_idx], data_rd_data);
        end else if (i_req) begin
            check_word({name, " instr_data"}, shadow[word_of(i_addr)], instr_data);
        end
        if (d_req && d_wr) begin
            shadow[d_idx] = merge_bytes(shadow[d_idx], d_wdata, d_mask);
        end
    endtask

    task automatic fill_words(input int first, input int count);
        for (int i = 0; i < count; i++) begin
            bus_cycle("fill", 1'b1, 1'b1, alias_addr(first + i), rand_word(), 4'hF,
                      1'b0, '0);
        end
    endtask

    task automatic mixed_traffic(input string name, input int n, input int data_span,
                                 input int instr_span, input logic allow_wr);
        logic d_req;
        logic d_wr;
        logic i_req;
        repeat (n) begin
            d_req = (rand_below(2) == 1);
            d_wr  = allow_wr && (rand_below(2) == 1);
            i_req = (rand_below(4) != 0);
            bus_cycle(name, d_req, d_wr, alias_addr(rand_below(data_span)), rand_word(),
                      byte_mask_t'(rand_below(16)), i_req, alias_addr(rand_below(instr_span)));
        end
    endtask

    // Called at the first negedge with run low
    task automatic check_dump(input string name, input word_t begin_addr, input int n_words);
        int    cyc;
        int    got;
        word_t exp_addr;
        cyc = 0;
        got = 0;
        while (halted !== 1'b1) begin
            if (cyc > n_words + 4) begin
                $display("Dump of %s never finished, halted stayed low", name);
                abort_run();
            end
            @(negedge clk);
            cyc++;
            if (dump_valid === 1'b1) begin
                exp_addr = {begin_addr[31:2], 2'b00} + word_t'(4 * got);
                check_word({name, " dump cycle"}, word_t'(got + 2), word_t'(cyc));
                check_word({name, " dump_addr"}, exp_addr, dump_addr);
                check_word({name, " dump_data"}, shadow[word_of(exp_addr)], dump_data);
                got++;
            end
        end
        check_word({name, " dump count"}, word_t'(n_words), word_t'(got));
        check_word({name, " halted cycle"}, word_t'(n_words + 2), word_t'(cyc));
    endtask

    task automatic hit_tohost(input string name, input word_t begin_addr, input int n_words);
        mem_idx_t idx;
        idx = word_of(tohost_addr);
        @(posedge clk);
        data_req     <= 1'b1;
        data_wr_en   <= 1'b1;
        data_addr    <= alias_addr(int'(idx));
        data_wr_data <= 32'd1;
        data_wr_mask <= 4'hF;
        @(negedge clk);
        check_bit({name, " run in hit cycle"}, 1'b1, run);
        @(posedge clk);
        data_req   <= 1'b0;
        data_wr_en <= 1'b0;
        @(negedge clk);
        check_bit({name, " run after hit"}, 1'b0, run);
        check_bit({name, " hit data_ack"}, 1'b1, data_ack);
        check_word({name, " hit old word"}, shadow[idx], data_rd_data);
        check_cause({name, " halt_cause"}, HALT_TOHOST, halt_cause);
        shadow[idx] = 32'd1;
        check_dump(name, begin_addr, n_words);
    endtask

    initial begin
        int n;
        seed         = 4684;
        rst          = 1'b1;
        instr_req    = 1'b0;
        instr_addr   = '0;
        data_req     = 1'b0;
        data_wr_en   = 1'b0;
        data_addr    = '0;
        data_wr_data = '0;
        data_wr_mask = '0;
        tohost_addr  = '0;
        sig_begin    = '0;
        sig_end      = '0;

        // Run 1 ends on tohost, dump of words 16 to 47
        start_run(TOHOST_ADDR, 32'h40, 32'hC0);
        fill_words(0, RUN1_WORDS);
        repeat (40) begin
            bus_cycle("masked write", 1'b1, 1'b1, alias_addr(rand_below(TOHOST_IDX)),
                      rand_word(), byte_mask_t'(rand_below(16)), 1'b0, '0);
        end
        repeat (40) begin
            bus_cycle("data read", 1'b1, 1'b0, alias_addr(rand_below(RUN1_WORDS)), '0, '0,
                      1'b0, '0);
        end
        mixed_traffic("fetch mix", 60, TOHOST_IDX, RUN1_WORDS, 1'b1);
        hit_tohost("tohost run", 32'h40, 32);

        // Run 2 times out, region of 200 words clamped
        @(posedge clk);
        start_run(TOHOST_ADDR, 32'h0, 32'd800);
        fill_words(RUN1_WORDS, RUN1_WORDS);
        mixed_traffic("read mix", 40, 2 * RUN1_WORDS, 2 * RUN1_WORDS, 1'b0);
        n = 0;
        while (run === 1'b1) begin
            if (n > RUN_LIMIT) begin
                $display("Run did not time out after %0d cycles", RUN_LIMIT);
                abort_run();
            end
            @(negedge clk);
            n++;
        end
        check_cause("timeout halt_cause", HALT_TIMEOUT, halt_cause);
        check_word("timeout run cycles", word_t'(RUN_LIMIT), word_t'(run_cycles));
        check_dump("timeout run", 32'h0, SIG_MAX_WORDS);

        // Run 3 with an empty region
        @(posedge clk);
        start_run(TOHOST_ADDR, 32'h100, 32'h100);
        hit_tohost("empty region", 32'h100, 0);

        $display("test passed");
        $finish;
    end

endmodule

/* tests/memsys_properties.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bound into memsys_top, sees the arbiter acks and the run control levels
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module memsys_properties (
    input logic clk,
    input logic rst,
    input logic run,
    input logic instr_req,
    input logic data_req,
    input logic instr_ack,
    input logic data_ack,
    input logic halted
);

    // One shared rdata register, so one ack per cycle
    ack_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(instr_ack && data_ack))
        else $error("instr_ack and data_ack high in the same cycle");

    instr_ack_has_req: assert property (@(posedge clk) disable iff (rst)
        instr_ack |-> $past(instr_req && run))
        else $error("instr_ack without a fetch request during run");

    data_ack_has_req: assert property (@(posedge clk) disable iff (rst)
        data_ack |-> $past(data_req && run))
        else $error("data_ack without a data request during run");

    // halted is sticky until reset
    halted_sticky: assert property (@(posedge clk)
        $fell(halted) |-> $past(rst))
        else $error("halted fell without a reset");

endmodule

bind memsys_top memsys_properties i_memsys_properties (
    .clk      (clk),
    .rst      (rst),
    .run      (run),
    .instr_req(instr_req),
    .data_req (data_req),
    .instr_ack(instr_ack),
    .data_ack (data_ack),
    .halted   (halted)
);

/* src/memsys_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Both read ports share the SRAM rdata register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module memsys_top import memsys_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        instr_req,
    input  word_t       instr_addr,
    output logic        instr_ack,
    output word_t       instr_data,
    input  logic        data_req,
    input  logic        data_wr_en,
    input  word_t       data_addr,
    input  word_t       data_wr_data,
    input  byte_mask_t  data_wr_mask,
    output logic        data_ack,
    output word_t       data_rd_data,
    input  word_t       tohost_addr,
    input  word_t       sig_begin,
    input  word_t       sig_end,
    output logic        run,
    output logic        halted,
    output halt_cause_e halt_cause,
    output logic        dump_valid,
    output word_t       dump_addr,
    output word_t       dump_data
);

    // SRAM side of the arbiter
    logic       mem_en;
    logic       mem_wr_en;
    mem_idx_t   mem_idx;
    word_t      mem_wdata;
    byte_mask_t mem_wmask;
    word_t      mem_rdata;

    // Dump read request
    logic     mem_req_dump;
    mem_idx_t dump_rd_addr;

    // Run control strobes
    logic hold_start;
    logic run_start;
    logic timer_stop;
    logic expired;
    logic dump_start;
    logic dump_done;

    assign instr_data   = mem_rdata;
    assign data_rd_data = mem_rdata;

    req_arbiter i_req_arbiter (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .instr_req   (instr_req),
        .data_req    (data_req),
        .data_wr_en  (data_wr_en),
        .instr_addr  (instr_addr),
        .data_addr   (data_addr),
        .data_wr_data(data_wr_data),
        .data_wr_mask(data_wr_mask),
        .mem_req_dump(mem_req_dump),
        .dump_rd_addr(dump_rd_addr),
        .mem_en      (mem_en),
        .mem_wr_en   (mem_wr_en),
        .mem_idx     (mem_idx),
        .mem_wdata   (mem_wdata),
        .mem_wmask   (mem_wmask),
        .instr_ack   (instr_ack),
        .data_ack    (data_ack)
    );

    spsram32 i_spsram32 (
        .clk  (clk),
        .en   (mem_en),
        .wr_en(mem_wr_en),
        .idx  (mem_idx),
        .wdata(mem_wdata),
        .wmask(mem_wmask),
        .rdata(mem_rdata)
    );

    run_timer i_run_timer (
        .clk       (clk),
        .rst       (rst),
        .hold_start(hold_start),
        .run_start (run_start),
        .stop      (timer_stop),
        .expired   (expired)
    );

    run_ctrl_fsm i_run_ctrl_fsm (
        .clk         (clk),
        .rst         (rst),
        .expired     (expired),
        .data_req    (data_req),
        .data_wr_en  (data_wr_en),
        .data_addr   (data_addr),
        .data_wr_data(data_wr_data),
        .tohost_addr (tohost_addr),
        .dump_done   (dump_done),
        .hold_start  (hold_start),
        .run_start   (run_start),
        .timer_stop  (timer_stop),
        .dump_start  (dump_start),
        .run         (run),
        .halted      (halted),
        .halt_cause  (halt_cause)
    );

    sig_dump i_sig_dump (
        .clk         (clk),
        .rst         (rst),
        .dump_start  (dump_start),
        .sig_begin   (sig_begin),
        .sig_end     (sig_end),
        .mem_rdata   (mem_rdata),
        .mem_req_dump(mem_req_dump),
        .dump_rd_addr(dump_rd_addr),
        .dump_valid  (dump_valid),
        .dump_addr   (dump_addr),
        .dump_data   (dump_data),
        .dump_done   (dump_done)
    );

endmodule

/* src/sig_dump.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Region is [sig_begin, sig_end) in words, clamped to SIG_MAX_WORDS
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module sig_dump import memsys_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     dump_start,
    input  word_t    sig_begin,
    input  word_t    sig_end,
    input  word_t    mem_rdata,
    output logic     mem_req_dump,
    output mem_idx_t dump_rd_addr,
    output logic     dump_valid,
    output word_t    dump_addr,
    output word_t    dump_data,
    output logic     dump_done
);

    logic [29:0] begin_w;
    logic [29:0] end_w;
    logic [29:0] span;
    sig_cnt_t    region_words;
    sig_cnt_t    remaining;
    word_t       rd_ptr;
    logic        active;
    logic        last_q;

    // Word count of the region
    assign begin_w = sig_begin[31:2];
    assign end_w   = sig_end[31:2];
    assign span    = end_w - begin_w;

    always_comb begin
        if (end_w <= begin_w) begin
            region_words = '0;
        end else if (span > 30'(SIG_MAX_WORDS)) begin
            region_words = SIG_CNT_W'(SIG_MAX_WORDS);
        end else begin
            region_words = span[SIG_CNT_W-1:0];
        end
    end

    assign mem_req_dump = active && (remaining != '0);
    assign dump_rd_addr = word_index(rd_ptr);

    always_ff @(posedge clk) begin
        if (rst) begin
            active     <= 1'b0;
            dump_valid <= 1'b0;
            last_q     <= 1'b0;
        end else begin
            dump_valid <= mem_req_dump;
            last_q     <= mem_req_dump && (remaining == SIG_CNT_W'(1));
            if (dump_start) begin
                active <= 1'b1;
            end else if (active && remaining <= SIG_CNT_W'(1)) begin
                active <= 1'b0;
            end
        end
    end

    // Read pointer, address delayed one cycle to meet rdata
    always_ff @(posedge clk) begin
        if (dump_start) begin
            rd_ptr    <= {sig_begin[31:2], 2'b00};
            remaining <= region_words;
        end else if (mem_req_dump) begin
            rd_ptr    <= rd_ptr + 32'd4;
            remaining <= remaining - 1'b1;
        end
        if (mem_req_dump) begin
            dump_addr <= rd_ptr;
        end
    end

    assign dump_data = mem_rdata;

    // Empty region finishes in its first active cycle
    assign dump_done = (active && remaining == '0) || last_q;

endmodule

/* src/run_ctrl_fsm.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tohost_addr must stay stable during a run, hit needs write data of 1
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module run_ctrl_fsm import memsys_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        expired,
    input  logic        data_req,
    input  logic        data_wr_en,
    input  word_t       data_addr,
    input  word_t       data_wr_data,
    input  word_t       tohost_addr,
    input  logic        dump_done,
    output logic        hold_start,
    output logic        run_start,
    output logic        timer_stop,
    output logic        dump_start,
    output logic        run,
    output logic        halted,
    output halt_cause_e halt_cause
);

    run_state_e state;
    run_state_e state_nxt;

    // High in the first cycle of each state
    logic entered;
    logic tohost_hit;

    assign tohost_hit = (state == ST_RUN) && data_req && data_wr_en
                        && (word_index(data_addr) == word_index(tohost_addr))
                        && (data_wr_data == 32'd1);

    always_comb begin
        state_nxt = state;
        case (state)
            ST_BOOT: begin
                if (expired) begin
                    state_nxt = ST_RUN;
                end
            end
            ST_RUN: begin
                if (tohost_hit || expired) begin
                    state_nxt = ST_DUMP;
                end
            end
            ST_DUMP: begin
                if (dump_done) begin
                    state_nxt = ST_DONE;
                end
            end
            default: begin
                // ST_DONE is left only through rst
                state_nxt = ST_DONE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_BOOT;
            entered    <= 1'b1;
            halt_cause <= HALT_NONE;
        end else begin
            state   <= state_nxt;
            entered <= (state_nxt != state);
            // Tohost wins if both land in one cycle
            if (state == ST_RUN) begin
                if (tohost_hit) begin
                    halt_cause <= HALT_TOHOST;
                end else if (expired) begin
                    halt_cause <= HALT_TIMEOUT;
                end
            end
        end
    end

    // One-cycle start strobes on state entry
    assign hold_start = entered && (state == ST_BOOT);
    assign run_start  = entered && (state == ST_RUN);
    assign dump_start = entered && (state == ST_DUMP);
    assign timer_stop = tohost_hit;

    assign run    = (state == ST_RUN);
    assign halted = (state == ST_DONE);

endmodule

/* src/run_timer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Start cycle counts as the first of N, expired comes in cycle N
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module run_timer import memsys_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic hold_start,
    input  logic run_start,
    input  logic stop,
    output logic expired
);

    timer_cnt_t cnt;
    logic       active;

    assign expired = active && (cnt == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
        end else if (stop) begin
            // Cancel without a pulse
            active <= 1'b0;
        end else if (hold_start || run_start) begin
            active <= 1'b1;
        end else if (expired) begin
            active <= 1'b0;
        end
    end

    // Load N-2 so that zero lands in the Nth cycle
    always_ff @(posedge clk) begin
        if (hold_start) begin
            cnt <= TIMER_W'(BOOT_HOLD - 2);
        end else if (run_start) begin
            cnt <= TIMER_W'(RUN_LIMIT - 2);
        end else if (active && cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

/* src/spsram32.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read-before-write, contents undefined after power up
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module spsram32 import memsys_pkg::*; (
    input  logic       clk,
    input  logic       en,
    input  logic       wr_en,
    input  mem_idx_t   idx,
    input  word_t      wdata,
    input  byte_mask_t wmask,
    output word_t      rdata
);

    localparam int NUM_BYTES = $bits(byte_mask_t);

    word_t mem [MEM_WORDS];

    // Registered read port
    // Holds the last word while en is low
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[idx];
        end
    end

    // Byte lanes written independently
    // A read in the same cycle still sees the old word
    always_ff @(posedge clk) begin
        if (en && wr_en) begin
            for (int b = 0; b < NUM_BYTES; b++) begin
                if (wmask[b]) begin
                    mem[idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

/* src/req_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed priority dump > data > instr, core requests count only while run
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module req_arbiter import memsys_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       run,
    input  logic       instr_req,
    input  logic       data_req,
    input  logic       data_wr_en,
    input  word_t      instr_addr,
    input  word_t      data_addr,
    input  word_t      data_wr_data,
    input  byte_mask_t data_wr_mask,
    input  logic       mem_req_dump,
    input  mem_idx_t   dump_rd_addr,
    output logic       mem_en,
    output logic       mem_wr_en,
    output mem_idx_t   mem_idx,
    output word_t      mem_wdata,
    output byte_mask_t mem_wmask,
    output logic       instr_ack,
    output logic       data_ack
);

    logic grant_data;
    logic grant_instr;

    // Data wins over instr, dump wins over both
    assign grant_data  = run && data_req && !mem_req_dump;
    assign grant_instr = run && instr_req && !data_req && !mem_req_dump;

    assign mem_en    = mem_req_dump || grant_data || grant_instr;
    assign mem_wr_en = grant_data && data_wr_en;
    assign mem_wdata = data_wr_data;
    assign mem_wmask = data_wr_mask;

    always_comb begin
        if (mem_req_dump) begin
            mem_idx = dump_rd_addr;
        end else if (grant_data) begin
            mem_idx = word_index(data_addr);
        end else begin
            mem_idx = word_index(instr_addr);
        end
    end

    // Ack one cycle after the granted request, alongside rdata
    always_ff @(posedge clk) begin
        if (rst) begin
            instr_ack <= 1'b0;
            data_ack  <= 1'b0;
        end else begin
            instr_ack <= grant_instr;
            data_ack  <= grant_data;
        end
    end

endmodule

/* src/memsys_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizes fixed here, no module parameters
// Timer loads assume BOOT_HOLD and RUN_LIMIT of at least 2
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package memsys_pkg;

    // Data word, also used for byte addresses
    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_mask_t;

    // Memory geometry
    localparam int MEM_WORDS = 512;
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);
    typedef logic [MEM_IDX_W-1:0] mem_idx_t;

    // Run control limits, in clock cycles
    localparam int BOOT_HOLD = 4;
    localparam int RUN_LIMIT = 600;
    localparam int TIMER_W   = $clog2(RUN_LIMIT);
    typedef logic [TIMER_W-1:0] timer_cnt_t;

    // Signature dump length limit
    localparam int SIG_MAX_WORDS = 128;
    localparam int SIG_CNT_W     = $clog2(SIG_MAX_WORDS + 1);
    typedef logic [SIG_CNT_W-1:0] sig_cnt_t;

    typedef enum logic [1:0] {
        ST_BOOT,
        ST_RUN,
        ST_DUMP,
        ST_DONE
    } run_state_e;

    typedef enum logic [1:0] {
        HALT_NONE,
        HALT_TOHOST,
        HALT_TIMEOUT
    } halt_cause_e;

    // Word index of a byte address
    // Bits 1:0 dropped, bits above the index wrap
    function automatic mem_idx_t word_index(word_t addr);
        return addr[MEM_IDX_W+1:2];
    endfunction

endpackage
